// ==== adcLink.f ====
hdl/adcLinkPkg.sv
hdl/uartRx.sv
hdl/uartTx.sv
hdl/adcPoller.sv
hdl/sampleAssembler.sv
hdl/adcLink.sv
verification/adcSensorModel.sv
verification/adcLinkTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module adcLinkTb \
    -f adcLink.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/VadcLinkTb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== verification/adcLinkTb.sv ====
`default_nettype none

module adcLinkTb import adcLinkPkg::*; ();

    localparam int ClkPeriod = 20;
    localparam int ResetCycles = 16;
    localparam int NumPolls = 10;
    localparam int SettleClks = (EopGapBits + 1) * ClksPerBit; // Gap plus one bit of slack.

    logic        clk = 1'b0;
    logic        arstN;
    logic        rx;
    logic        tx;
    sampleT      adc0;
    sampleT      adc1;
    sampleT      adc2;
    sampleT      adc3;
    logic [1:0]  replyLen;
    logic [23:0] replyBytes;
    byteT        cmdByte;
    int          cmdCount;
    int          startCycle;
    int          replyCount;
    sampleT      expAdc [4];
    channelT     expChannel;
    int          lastStart;
    int          pollsDone;
    int          seed;
    int          errors;
    int          testErrors;
    int          testsRun;
    string       testName;

    always #(ClkPeriod / 2) clk = ~clk;

    adcLink uut (
        .clk   (clk),
        .arstN (arstN),
        .rx    (rx),
        .tx    (tx),
        .adc0  (adc0),
        .adc1  (adc1),
        .adc2  (adc2),
        .adc3  (adc3)
    );

    adcSensorModel sensor (
        .clk        (clk),
        .tx         (tx),
        .rx         (rx),
        .replyLen   (replyLen),
        .replyBytes (replyBytes),
        .cmdByte    (cmdByte),
        .cmdCount   (cmdCount),
        .startCycle (startCycle),
        .replyCount (replyCount)
    );

    task automatic compareValue(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s: %s expected %h, actual %h",
                testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkRegisters();
        compareValue("adc0", int'(expAdc[0]), int'(adc0));
        compareValue("adc1", int'(expAdc[1]), int'(adc1));
        compareValue("adc2", int'(expAdc[2]), int'(adc2));
        compareValue("adc3", int'(expAdc[3]), int'(adc3));
    endtask

    task automatic finishTest();
        $display("%s %s", testErrors == 0 ? "PASS" : "FAIL", testName);
        errors += testErrors;
        testErrors = 0;
        testsRun++;
    endtask

    // One poll cycle with a reply of len bytes.
    task automatic runPoll(input string name, input logic [1:0] len);
        logic [23:0] bytes;
        testName = name;
        bytes = 24'($random(seed));
        @(negedge clk);
        replyLen = len;
        replyBytes = bytes;
        wait (cmdCount == pollsDone + 1);
        expChannel = expChannel + 1'b1;
        compareValue("command", int'(CmdBase) + int'(expChannel), int'(cmdByte));
        if (pollsDone > 0) compareValue("period", PollPeriod, startCycle - lastStart);
        lastStart = startCycle;
        wait (replyCount == pollsDone + 1);
        pollsDone++;
        repeat (SettleClks) @(negedge clk);
        if (len == 2'(SampleBytes)) begin
            expAdc[expChannel] = sampleT'(int'(bytes[7:0]) + int'(bytes[15:8]) * 256);
        end
        checkRegisters();
        finishTest();
    endtask

    initial begin
        #(2 * NumPolls * PollPeriod * ClkPeriod);
        $display("Watchdog expired before all polls completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        arstN = 1'b0;
        replyLen = 2'd2;
        replyBytes = '0;
        seed = 32'h837;
        expChannel = '0;
        lastStart = 0;
        pollsDone = 0;
        errors = 0;
        testErrors = 0;
        testsRun = 0;
        for (int i = 0; i < 4; i++) expAdc[i] = '0;
        repeat (ResetCycles) @(negedge clk);
        arstN = 1'b1;

        testName = "reset state";
        checkRegisters();
        repeat (PollPeriod) begin
            @(negedge clk);
            assert (tx) else begin
                $display("tx left idle before the first poll period ended");
                testErrors++;
            end
        end
        finishTest();

        runPoll("store ch1", 2'd2);
        runPoll("store ch2", 2'd2);
        runPoll("store ch3", 2'd2);
        runPoll("store ch0", 2'd2);
        runPoll("reject 1 byte ch1", 2'd1);
        runPoll("reject 3 bytes ch2", 2'd3);
        runPoll("store ch3 again", 2'd2);
        runPoll("store ch0 again", 2'd2);
        runPoll("recover ch1", 2'd2);
        runPoll("recover ch2", 2'd2);

        $display("%0d tests run, %0d errors", testsRun, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/adcSensorModel.sv ====
`default_nettype none

module adcSensorModel import adcLinkPkg::*; (
    input  wire logic        clk,
    input  wire logic        tx,
    output logic             rx,
    input  wire logic [1:0]  replyLen,
    input  wire logic [23:0] replyBytes,
    output byteT             cmdByte,
    output int               cmdCount,
    output int               startCycle,
    output int               replyCount
);

    int          cycle = 0;
    byteT        cmd;
    logic [1:0]  len;
    logic [23:0] bytes;

    always @(negedge clk) cycle <= cycle + 1;

    task automatic sendBit(input logic value);
        rx = value;
        repeat (ClksPerBit) @(negedge clk);
    endtask

    // Start bit, LSB first, stop bit.
    task automatic sendByte(input byteT value);
        sendBit(1'b0);
        for (int i = 0; i < 8; i++) sendBit(value[i]);
        sendBit(1'b1);
    endtask

    initial begin
        rx = 1'b1;
        cmdByte = '0;
        cmdCount = 0;
        startCycle = 0;
        replyCount = 0;
        forever begin
            @(negedge clk);
            if (!tx) begin
                startCycle = cycle;
                repeat (ClksPerBit / 2) @(negedge clk); // Middle of the start bit.
                for (int i = 0; i < 8; i++) begin
                    repeat (ClksPerBit) @(negedge clk);
                    cmd[i] = tx;
                end
                repeat (ClksPerBit) @(negedge clk); // Middle of the stop bit.
                cmdByte = cmd;
                len = replyLen;
                bytes = replyBytes;
                cmdCount++;
                repeat (ClksPerBit / 2) @(negedge clk);
                // Back to back, so the gap only follows the last byte.
                for (int n = 0; n < int'(len); n++) sendByte(bytes[8*n +: 8]);
                replyCount++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/adcLink.sv ====
`default_nettype none

module adcLink import adcLinkPkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic rx,
    output logic      tx,
    output sampleT    adc0,
    output sampleT    adc1,
    output sampleT    adc2,
    output sampleT    adc3
);

    byteT    txData;
    logic    txValid;
    logic    txReady;
    channelT channel;
    byteT    rxData;
    logic    rxValid;
    logic    rxEop;

    // Command side.
    adcPoller poller (
        .clk     (clk),
        .arstN   (arstN),
        .txData  (txData),
        .txValid (txValid),
        .txReady (txReady),
        .channel (channel)
    );

    uartTx txUart (
        .clk     (clk),
        .arstN   (arstN),
        .txData  (txData),
        .txValid (txValid),
        .txReady (txReady),
        .tx      (tx)
    );

    uartRx rxUart (
        .clk     (clk),
        .arstN   (arstN),
        .rx      (rx),
        .rxData  (rxData),
        .rxValid (rxValid),
        .rxEop   (rxEop)
    );

    sampleAssembler assembler (
        .clk     (clk),
        .arstN   (arstN),
        .rxData  (rxData),
        .rxValid (rxValid),
        .rxEop   (rxEop),
        .channel (channel),
        .adc0    (adc0),
        .adc1    (adc1),
        .adc2    (adc2),
        .adc3    (adc3)
    );

endmodule

`default_nettype wire

// ==== hdl/sampleAssembler.sv ====
`default_nettype none

module sampleAssembler import adcLinkPkg::*; (
    input  wire logic    clk,
    input  wire logic    arstN,
    input  wire byteT    rxData,
    input  wire logic    rxValid,
    input  wire logic    rxEop,
    input  wire channelT channel,
    output sampleT       adc0,
    output sampleT       adc1,
    output sampleT       adc2,
    output sampleT       adc3
);

    sampleT    shiftReg;
    byteCountT byteCnt;
    logic      lengthOk;

    assign lengthOk = byteCnt == byteCountT'(SampleBytes);

    // First byte ends up low.
    always_ff @(posedge clk) begin
        if (rxEop) begin
            shiftReg <= '0;
        end else if (rxValid) begin
            shiftReg <= {rxData, shiftReg[15:8]};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            byteCnt <= '0;
        end else if (rxEop) begin
            byteCnt <= '0;
        end else if (rxValid && byteCnt != byteCountT'(SampleBytes + 1)) begin
            byteCnt <= byteCnt + 1'b1; // Saturates one past a good length.
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            adc0 <= '0;
            adc1 <= '0;
            adc2 <= '0;
            adc3 <= '0;
        end else if (rxEop && lengthOk) begin
            case (channel)
                2'd0: adc0 <= shiftReg;
                2'd1: adc1 <= shiftReg;
                2'd2: adc2 <= shiftReg;
                default: adc3 <= shiftReg;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/adcPoller.sv ====
`default_nettype none

module adcPoller import adcLinkPkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    output byteT      txData,
    output logic      txValid,
    input  wire logic txReady,
    output channelT   channel
);

    pollTimerT pollCnt;
    logic      wrap;
    channelT   nextChannel;

    assign wrap = pollCnt == pollTimerT'(PollPeriod - 1);
    assign nextChannel = channel + 1'b1;

    // Free running, unaffected by back-pressure.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pollCnt <= '0;
        end else if (wrap) begin
            pollCnt <= '0;
        end else begin
            pollCnt <= pollCnt + 1'b1;
        end
    end

    // A pending command holds until the transmitter takes it.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            channel <= '0;
            txValid <= 1'b0;
        end else if (wrap && (!txValid || txReady)) begin
            channel <= nextChannel;
            txValid <= 1'b1;
        end else if (txReady) begin
            txValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrap && (!txValid || txReady)) begin
            txData <= CmdBase + byteT'(nextChannel);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uartTx.sv ====
`default_nettype none

module uartTx import adcLinkPkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire byteT txData,
    input  wire logic txValid,
    output logic      txReady,
    output logic      tx
);

    typedef enum logic [1:0] {Idle, Start, Data, Stop} txStateT;

    txStateT    state;
    bitTimerT   bitTimer;
    logic [2:0] bitIdx;
    byteT       shiftReg;
    logic       bitTick;

    assign txReady = state == Idle;
    assign bitTick = bitTimer == bitTimerT'(ClksPerBit - 1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
            bitTimer <= '0;
            bitIdx <= '0;
            tx <= 1'b1;
        end else begin
            bitTimer <= bitTick ? '0 : bitTimer + 1'b1;
            case (state)
                Idle: begin
                    bitTimer <= '0;
                    bitIdx <= '0;
                    if (txValid) begin
                        tx <= 1'b0; // Start bit.
                        state <= Start;
                    end
                end
                Start: begin
                    if (bitTick) begin
                        tx <= shiftReg[0];
                        state <= Data;
                    end
                end
                Data: begin
                    if (bitTick) begin
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7) begin
                            tx <= 1'b1;
                            state <= Stop;
                        end else begin
                            tx <= shiftReg[1]; // Next bit, shifted in this same edge.
                        end
                    end
                end
                default: if (bitTick) state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (txValid && txReady) begin
            shiftReg <= txData;
        end else if (state == Data && bitTick) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uartRx.sv ====
`default_nettype none

module uartRx import adcLinkPkg::*; (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic rx,
    output byteT      rxData,
    output logic      rxValid,
    output logic      rxEop
);

    typedef enum logic [1:0] {Idle, Start, Data, Stop} rxStateT;

    rxStateT   state;
    logic      rxMeta;
    logic      rxSync;
    bitTimerT  bitTimer;
    logic [2:0] bitIdx;
    byteT      shiftReg;
    gapTimerT  gapTimer;
    logic      pending; // Bytes seen since the last rxEop.
    logic      bitTick;
    logic      stopTick;

    assign bitTick = bitTimer == bitTimerT'(ClksPerBit - 1);
    assign stopTick = (state == Stop) && bitTick;
    assign rxData = shiftReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
            bitTimer <= '0;
            bitIdx <= '0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            case (state)
                Idle: begin
                    bitTimer <= '0;
                    bitIdx <= '0;
                    if (!rxSync) state <= Start;
                end
                Start: begin
                    if (bitTimer == bitTimerT'(ClksPerBit / 2 - 1)) begin
                        bitTimer <= '0;
                        state <= rxSync ? Idle : Data; // Glitch, not a start bit.
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                Data: begin
                    if (bitTick) begin
                        bitTimer <= '0;
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7) state <= Stop;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                default: begin
                    if (bitTick) begin
                        state <= Idle;
                        rxValid <= rxSync;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge clk) begin
        if (state == Data && bitTick) shiftReg <= {rxSync, shiftReg[7:1]};
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            gapTimer <= '0;
            pending <= 1'b0;
            rxEop <= 1'b0;
        end else begin
            rxEop <= 1'b0;
            if (stopTick && rxSync) pending <= 1'b1;
            if (state != Idle || !rxSync) begin
                gapTimer <= '0;
            end else if (pending) begin
                if (gapTimer == gapTimerT'(EopGapClks - 1)) begin
                    gapTimer <= '0;
                    pending <= 1'b0;
                    rxEop <= 1'b1;
                end else begin
                    gapTimer <= gapTimer + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/adcLinkPkg.sv ====
`default_nettype none

package adcLinkPkg;

    // Bit timing. A board build changes only these two.
    localparam int ClksPerBit = 16;
    localparam int EopGapBits = 4;

    // Idle time counted from the middle of the stop bit.
    localparam int EopGapClks = EopGapBits * ClksPerBit + ClksPerBit / 2;

    localparam int PollPeriod = 2000; // Clock cycles between commands.
    localparam int SampleBytes = 2;

    localparam int BitCntW = $clog2(ClksPerBit);
    localparam int GapCntW = $clog2(EopGapClks);
    localparam int PollCntW = $clog2(PollPeriod);
    localparam int ByteCntW = $clog2(SampleBytes + 2);

    typedef logic [7:0] byteT;
    typedef logic [15:0] sampleT;
    typedef logic [1:0] channelT;

    typedef logic [BitCntW-1:0] bitTimerT;
    typedef logic [GapCntW-1:0] gapTimerT;
    typedef logic [PollCntW-1:0] pollTimerT;
    typedef logic [ByteCntW-1:0] byteCountT;

    localparam byteT CmdBase = 8'hA1; // Command for channel 0.

endpackage

`default_nettype wire
